//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_tap_top
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- rtl/jtag_tap_pkg.sv
// JTAG TAP shared definitions

package jtag_tap_pkg;

  // Instruction register
  localparam int unsigned IrWidth = 5;

  typedef logic [IrWidth-1:0] ir_t;

  // Supported instruction codes, anything else acts as BYPASS
  typedef enum logic [IrWidth-1:0] {
    InstrIdcode  = 5'b00010,
    InstrMemory  = 5'b00100,  // User chain 1
    InstrFifo    = 5'b00101,  // User chain 2
    InstrConfreg = 5'b00110,  // User chain 3
    InstrBypass  = 5'b11111
  } instr_e;

  // Fixed Capture-IR pattern, LSBs 01 as the standard requires
  localparam ir_t IrCapture = 5'b00101;

  // Device identification
  localparam int unsigned IdcodeWidth = 32;

  typedef logic [IdcodeWidth-1:0] idcode_t;

  // Version 1, part 0, manufacturer 0x6d9
  localparam idcode_t DefaultIdcode = 32'h1000_0db3;

  // TAP controller states, IEEE 1149.1 reference encoding
  typedef enum logic [3:0] {
    TestLogicReset = 4'hF,
    RunTestIdle    = 4'hC,
    SelectDrScan   = 4'h7,
    CaptureDr      = 4'h6,
    ShiftDr        = 4'h2,
    Exit1Dr        = 4'h1,
    PauseDr        = 4'h3,
    Exit2Dr        = 4'h0,
    UpdateDr       = 4'h5,
    SelectIrScan   = 4'h4,
    CaptureIr      = 4'hE,
    ShiftIr        = 4'hA,
    Exit1Ir        = 4'h9,
    PauseIr        = 4'hB,
    Exit2Ir        = 4'h8,
    UpdateIr       = 4'hD
  } tap_state_e;

endpackage

//--- rtl/tap_data_path.sv
// TAP data registers and TDO mux
`timescale 1ns/100ps

module tap_data_path #(
  parameter jtag_tap_pkg::idcode_t IdcodeValue = jtag_tap_pkg::DefaultIdcode
) (
  input  logic tck_i,
  input  logic rst_ni,
  input  logic td_i,            // Serial data from pad
  input  logic shift_ir_i,
  input  logic shift_dr_i,
  input  logic capture_dr_i,
  input  logic exit1_dr_i,
  input  logic idcode_sel_i,
  input  logic memory_sel_i,
  input  logic fifo_sel_i,
  input  logic confreg_sel_i,
  input  logic bypass_sel_i,
  input  logic ir_tdo_i,        // IR serial out
  input  logic memory_tdo_i,    // User chain returns
  input  logic fifo_tdo_i,
  input  logic confreg_tdo_i,
  output logic td_o             // To pad, changes on falling edge
);

  import jtag_tap_pkg::*;

  logic idcode_tdo;
  logic bypass_q;
  logic tdo_d;

  // IDCODE register, reloaded on Capture-DR and on Exit1-DR
  tap_shift_reg #(
    .data_t       (idcode_t),
    .ResetValue   (IdcodeValue),
    .CaptureValue (IdcodeValue)
  ) u_idcode (
    .tck_i     (tck_i),
    .rst_ni    (rst_ni),
    .capture_i (idcode_sel_i & (capture_dr_i | exit1_dr_i)),
    .shift_i   (idcode_sel_i & shift_dr_i),
    .sdi_i     (td_i),
    .data_o    (),              // Serial access only
    .sdo_o     (idcode_tdo)
  );

  // Single-bit BYPASS, captures 0 then follows TDI
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      bypass_q <= 1'b0;
    end
    else if (capture_dr_i)
    begin
      bypass_q <= 1'b0;
    end
    else if (shift_dr_i)
    begin
      bypass_q <= td_i;
    end
  end

  // Source for the next TDO bit
  always_comb
  begin
    tdo_d = bypass_q;
    if (shift_ir_i)
    begin
      tdo_d = ir_tdo_i;
    end
    else
    begin
      case (1'b1)
        idcode_sel_i:  tdo_d = idcode_tdo;
        memory_sel_i:  tdo_d = memory_tdo_i;
        fifo_sel_i:    tdo_d = fifo_tdo_i;
        confreg_sel_i: tdo_d = confreg_tdo_i;
        bypass_sel_i:  tdo_d = bypass_q;
        default:       tdo_d = bypass_q;
      endcase
    end
  end

  // TDO launches on the falling edge, host samples on the rising edge
  always_ff @(negedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      td_o <= 1'b0;
    end
    else
    begin
      td_o <= tdo_d;
    end
  end

  // Chain returns and registers must stay driven
  a_tdo_known: assert property (
    @(posedge tck_i) disable iff (!rst_ni)
    !$isunknown(td_o)
  ) else $error("tap_data_path: td_o unknown");

endmodule

//--- rtl/tap_fsm.sv
// TAP state machine
`timescale 1ns/100ps

module tap_fsm (
  input  logic tck_i,
  input  logic rst_ni,
  input  logic tms_i,               // Test mode select from pad
  output logic test_logic_reset_o,
  output logic capture_dr_o,
  output logic shift_dr_o,
  output logic exit1_dr_o,
  output logic update_dr_o,
  output logic capture_ir_o,
  output logic shift_ir_o,
  output logic update_ir_o
);

  import jtag_tap_pkg::*;

  tap_state_e state_q, state_d;

  // Standard 1149.1 transition table
  // Five TMS-high clocks reach Test-Logic-Reset from any state
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      TestLogicReset: state_d = tms_i ? TestLogicReset : RunTestIdle;
      RunTestIdle:    state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectDrScan:   state_d = tms_i ? SelectIrScan   : CaptureDr;
      CaptureDr:      state_d = tms_i ? Exit1Dr        : ShiftDr;
      ShiftDr:        state_d = tms_i ? Exit1Dr        : ShiftDr;
      Exit1Dr:        state_d = tms_i ? UpdateDr       : PauseDr;
      PauseDr:        state_d = tms_i ? Exit2Dr        : PauseDr;
      Exit2Dr:        state_d = tms_i ? UpdateDr       : ShiftDr;
      UpdateDr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
      SelectIrScan:   state_d = tms_i ? TestLogicReset : CaptureIr;
      CaptureIr:      state_d = tms_i ? Exit1Ir        : ShiftIr;
      ShiftIr:        state_d = tms_i ? Exit1Ir        : ShiftIr;
      Exit1Ir:        state_d = tms_i ? UpdateIr       : PauseIr;
      PauseIr:        state_d = tms_i ? Exit2Ir        : PauseIr;
      Exit2Ir:        state_d = tms_i ? UpdateIr       : ShiftIr;
      UpdateIr:       state_d = tms_i ? SelectDrScan   : RunTestIdle;
      default:        state_d = TestLogicReset;  // Unreachable codes recover
    endcase
  end

  // State register resets into Test-Logic-Reset
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= TestLogicReset;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Strobes follow the current state exactly
  assign test_logic_reset_o = (state_q == TestLogicReset);
  assign capture_dr_o       = (state_q == CaptureDr);
  assign shift_dr_o         = (state_q == ShiftDr);
  assign exit1_dr_o         = (state_q == Exit1Dr);
  assign update_dr_o        = (state_q == UpdateDr);
  assign capture_ir_o       = (state_q == CaptureIr);
  assign shift_ir_o         = (state_q == ShiftIr);
  assign update_ir_o        = (state_q == UpdateIr);

  // DR strobes seen by the user chains never overlap
  a_dr_strobes_excl: assert property (
    @(posedge tck_i) disable iff (!rst_ni)
    $onehot0({capture_dr_o, shift_dr_o, update_dr_o})
  ) else $error("tap_fsm: DR strobes overlap in state %s", state_q.name());

endmodule

//--- rtl/tap_instr_reg.sv
// JTAG instruction register and decode
`timescale 1ns/100ps

module tap_instr_reg (
  input  logic              tck_i,
  input  logic              rst_ni,
  input  logic              td_i,                // Serial data from pad
  input  logic              capture_ir_i,
  input  logic              shift_ir_i,
  input  logic              update_ir_i,
  input  logic              test_logic_reset_i,
  output jtag_tap_pkg::ir_t instr_o,             // Active instruction
  output logic              idcode_sel_o,
  output logic              memory_sel_o,
  output logic              fifo_sel_o,
  output logic              confreg_sel_o,
  output logic              bypass_sel_o,
  output logic              ir_tdo_o             // IR serial out
);

  import jtag_tap_pkg::*;

  ir_t ir_shift;  // Shift stage contents
  ir_t instr_q;   // Latched instruction

  // Shift stage, captures fixed pattern for fault detection
  tap_shift_reg #(
    .data_t       (ir_t),
    .ResetValue   ('0),
    .CaptureValue (IrCapture)
  ) u_ir_shift (
    .tck_i     (tck_i),
    .rst_ni    (rst_ni),
    .capture_i (capture_ir_i),
    .shift_i   (shift_ir_i),
    .sdi_i     (td_i),
    .data_o    (ir_shift),
    .sdo_o     (ir_tdo_o)
  );

  // Update stage, IDCODE active after any reset
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      instr_q <= InstrIdcode;
    end
    else if (test_logic_reset_i)
    begin
      instr_q <= InstrIdcode;  // Held while in Test-Logic-Reset
    end
    else if (update_ir_i)
    begin
      instr_q <= ir_shift;
    end
  end

  assign instr_o = instr_q;

  // Data register select, exactly one active
  always_comb
  begin
    idcode_sel_o  = 1'b0;
    memory_sel_o  = 1'b0;
    fifo_sel_o    = 1'b0;
    confreg_sel_o = 1'b0;
    bypass_sel_o  = 1'b0;
    case (instr_q)
      InstrIdcode:  idcode_sel_o  = 1'b1;
      InstrMemory:  memory_sel_o  = 1'b1;
      InstrFifo:    fifo_sel_o    = 1'b1;
      InstrConfreg: confreg_sel_o = 1'b1;
      InstrBypass:  bypass_sel_o  = 1'b1;
      default:      bypass_sel_o  = 1'b1;  // Undefined codes
    endcase
  end

  // TDO mux in the data path relies on this
  a_sel_onehot: assert property (
    @(posedge tck_i) disable iff (!rst_ni)
    $onehot({idcode_sel_o, memory_sel_o, fifo_sel_o, confreg_sel_o, bypass_sel_o})
  ) else $error("tap_instr_reg: selects not one-hot for code %b", instr_q);

endmodule

//--- rtl/tap_shift_reg.sv
// TAP capture and shift register
`timescale 1ns/100ps

module tap_shift_reg #(
  parameter type   data_t       = logic [7:0],  // Packed payload
  parameter data_t ResetValue   = '0,
  parameter data_t CaptureValue = '0            // Parallel load on capture
) (
  input  logic  tck_i,
  input  logic  rst_ni,
  input  logic  capture_i,  // Parallel load strobe
  input  logic  shift_i,    // Serial shift strobe
  input  logic  sdi_i,      // Serial in, enters MSB
  output data_t data_o,
  output logic  sdo_o       // Serial out, LSB first
);

  localparam int unsigned Width = $bits(data_t);

  logic [Width-1:0] data_q;

  // Capture wins over shift, strobes are exclusive anyway
  always_ff @(posedge tck_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      data_q <= ResetValue;
    end
    else if (capture_i)
    begin
      data_q <= CaptureValue;
    end
    else if (shift_i)
    begin
      data_q <= {sdi_i, data_q[Width-1:1]};  // Shift right toward TDO
    end
  end

  assign data_o = data_t'(data_q);
  assign sdo_o  = data_q[0];

  // Callers decode both strobes from one TAP state
  a_capture_shift_excl: assert property (
    @(posedge tck_i) disable iff (!rst_ni)
    !(capture_i && shift_i)
  ) else $error("tap_shift_reg: capture and shift high together");

endmodule

//--- rtl/tap_top.sv
// JTAG TAP controller top
`timescale 1ns/100ps

module tap_top #(
  parameter jtag_tap_pkg::idcode_t IdcodeValue = jtag_tap_pkg::DefaultIdcode
) (
  input  logic tck_i,          // Test clock pad
  input  logic rst_ni,         // Test reset pad
  input  logic tms_i,          // Test mode select pad
  input  logic td_i,           // Test data in pad
  output logic td_o,           // Test data out pad
  output logic scan_in_o,      // Serial data to user chains
  output logic shift_dr_o,     // TAP strobes for user chains
  output logic capture_dr_o,
  output logic update_dr_o,
  output logic memory_sel_o,   // User chain selects
  output logic fifo_sel_o,
  output logic confreg_sel_o,
  input  logic memory_out_i,   // User chain returns
  input  logic fifo_out_i,
  input  logic confreg_out_i
);

  logic test_logic_reset;
  logic exit1_dr;
  logic capture_ir;
  logic shift_ir;
  logic update_ir;
  logic idcode_sel;
  logic bypass_sel;
  logic ir_tdo;

  // User chains see TDI directly
  assign scan_in_o = td_i;

  tap_fsm u_fsm (
    .tck_i              (tck_i),
    .rst_ni             (rst_ni),
    .tms_i              (tms_i),
    .test_logic_reset_o (test_logic_reset),
    .capture_dr_o       (capture_dr_o),
    .shift_dr_o         (shift_dr_o),
    .exit1_dr_o         (exit1_dr),
    .update_dr_o        (update_dr_o),
    .capture_ir_o       (capture_ir),
    .shift_ir_o         (shift_ir),
    .update_ir_o        (update_ir)
  );

  tap_instr_reg u_instr_reg (
    .tck_i              (tck_i),
    .rst_ni             (rst_ni),
    .td_i               (td_i),
    .capture_ir_i       (capture_ir),
    .shift_ir_i         (shift_ir),
    .update_ir_i        (update_ir),
    .test_logic_reset_i (test_logic_reset),
    .instr_o            (),           // Decoded selects used instead
    .idcode_sel_o       (idcode_sel),
    .memory_sel_o       (memory_sel_o),
    .fifo_sel_o         (fifo_sel_o),
    .confreg_sel_o      (confreg_sel_o),
    .bypass_sel_o       (bypass_sel),
    .ir_tdo_o           (ir_tdo)
  );

  tap_data_path #(
    .IdcodeValue (IdcodeValue)
  ) u_data_path (
    .tck_i         (tck_i),
    .rst_ni        (rst_ni),
    .td_i          (td_i),
    .shift_ir_i    (shift_ir),
    .shift_dr_i    (shift_dr_o),
    .capture_dr_i  (capture_dr_o),
    .exit1_dr_i    (exit1_dr),
    .idcode_sel_i  (idcode_sel),
    .memory_sel_i  (memory_sel_o),
    .fifo_sel_i    (fifo_sel_o),
    .confreg_sel_i (confreg_sel_o),
    .bypass_sel_i  (bypass_sel),
    .ir_tdo_i      (ir_tdo),
    .memory_tdo_i  (memory_out_i),
    .fifo_tdo_i    (fifo_out_i),
    .confreg_tdo_i (confreg_out_i),
    .td_o          (td_o)
  );

endmodule

//--- tb.f
rtl/jtag_tap_pkg.sv
rtl/tap_fsm.sv
rtl/tap_shift_reg.sv
rtl/tap_instr_reg.sv
rtl/tap_data_path.sv
rtl/tap_top.sv
test/tb_clk_gen.sv
test/tb_tap_top.sv

//--- test/tb_clk_gen.sv
// Test clock and reset source
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int Period      = 4,  // TCK period in ns
  parameter int ResetCycles = 4
) (
  output logic tck_o,
  output logic rst_no
);

  // Free-running TCK
  initial
  begin
    tck_o = 1'b0;
    forever
    begin
      #(Period / 2) tck_o = ~tck_o;
    end
  end

  // Release on a falling edge, clear of the capture edge
  initial
  begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge tck_o);
    @(negedge tck_o);
    rst_no = 1'b1;
  end

endmodule

//--- test/tb_tap_top.sv
// JTAG TAP controller testbench
`timescale 1ns/100ps

module tb_tap_top;

  import jtag_tap_pkg::*;

  localparam int TckPeriod    = 4;
  localparam int ResetCycles  = 4;
  localparam int ScanBits     = 215;  // All shift cycles in the run
  localparam int NumScans     = 14;
  localparam int ScanOverhead = 8;    // TMS walk per scan
  localparam int WatchdogNs   =
    (ScanBits + NumScans * ScanOverhead + ResetCycles + 40) * TckPeriod;

  logic tck;
  logic rst_n;
  logic tms_i;
  logic td_i;
  logic td_o;
  logic scan_in_o;
  logic shift_dr_o;
  logic capture_dr_o;
  logic update_dr_o;
  logic memory_sel_o;
  logic fifo_sel_o;
  logic confreg_sel_o;
  logic memory_out_i;
  logic fifo_out_i;
  logic confreg_out_i;

  logic [63:0] chain_ret [3];  // Return streams of the user chains
  int idcode_errs;
  int ir_errs;
  int bit_errs;
  int count_errs;
  logic count_en;              // Strobe counting window
  int cap_cnt;
  int shift_cnt;
  int upd_cnt;

  tb_clk_gen #(
    .Period      (TckPeriod),
    .ResetCycles (ResetCycles)
  ) u_clk_gen (
    .tck_o  (tck),
    .rst_no (rst_n)
  );

  tap_top #(
    .IdcodeValue (DefaultIdcode)
  ) dut0 (
    .tck_i         (tck),
    .rst_ni        (rst_n),
    .tms_i         (tms_i),
    .td_i          (td_i),
    .td_o          (td_o),
    .scan_in_o     (scan_in_o),
    .shift_dr_o    (shift_dr_o),
    .capture_dr_o  (capture_dr_o),
    .update_dr_o   (update_dr_o),
    .memory_sel_o  (memory_sel_o),
    .fifo_sel_o    (fifo_sel_o),
    .confreg_sel_o (confreg_sel_o),
    .memory_out_i  (memory_out_i),
    .fifo_out_i    (fifo_out_i),
    .confreg_out_i (confreg_out_i)
  );

  task automatic check_idcode(input idcode_t got, input idcode_t exp, input string what);
    if (got !== exp)
    begin
      idcode_errs++;
      $display("error @ %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_ir(input ir_t got, input ir_t exp, input string what);
    if (got !== exp)
    begin
      ir_errs++;
      $display("error @ %0t: %s read %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      bit_errs++;
      $display("error @ %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input tap_state_e st);
    if (got != exp)
    begin
      count_errs++;
      $display("error @ %0t: strobe of %s high for %0d cycles, expected %0d",
               $time, st.name(), got, exp);
    end
  endtask

  // Strobes are stable around the falling edge
  always @(negedge tck)
  begin
    if (count_en)
    begin
      if (capture_dr_o) cap_cnt++;
      if (shift_dr_o) shift_cnt++;
      if (update_dr_o) upd_cnt++;
    end
  end

  // One TMS/TDI value for the next rising edge
  task automatic step(input logic tms, input logic tdi);
    @(posedge tck);
    tms_i <= tms;
    td_i  <= tdi;
  endtask

  // Called with the Shift state entered at the next edge; ends in Run-Test-Idle
  task automatic shift_bits(input int n, input logic [63:0] din,
                            output logic [63:0] dout, output logic [63:0] sin);
    int i;
    dout = '0;
    sin  = '0;
    @(posedge tck);  // Capture done, now in Shift
    for (i = 0; i < n; i++)
    begin
      tms_i         <= (i == n - 1);  // Last bit leaves to Exit1
      td_i          <= din[i];
      memory_out_i  <= chain_ret[0][i];
      fifo_out_i    <= chain_ret[1][i];
      confreg_out_i <= chain_ret[2][i];
      @(posedge tck);
      dout[i] = td_o;       // Launched on the previous falling edge
      sin[i]  = scan_in_o;
    end
    tms_i <= 1'b1;          // Exit1 -> Update
    td_i  <= 1'b0;
    step(1'b0, 1'b0);       // Update -> Run-Test-Idle
    @(posedge tck);
  endtask

  task automatic scan_dr(input int n, input logic [63:0] din,
                         output logic [63:0] dout, output logic [63:0] sin);
    step(1'b1, 1'b0);  // Select-DR
    step(1'b0, 1'b0);  // Capture-DR
    step(1'b0, 1'b0);  // Shift-DR
    shift_bits(n, din, dout, sin);
  endtask

  task automatic scan_ir(input int n, input logic [63:0] din,
                         output logic [63:0] dout, output logic [63:0] sin);
    step(1'b1, 1'b0);  // Select-DR
    step(1'b1, 1'b0);  // Select-IR
    step(1'b0, 1'b0);  // Capture-IR
    step(1'b0, 1'b0);  // Shift-IR
    shift_bits(n, din, dout, sin);
  endtask

  task automatic load_ir(input ir_t code);
    logic [63:0] din;
    logic [63:0] dout;
    logic [63:0] sin;
    din = '0;
    din[IrWidth-1:0] = code;
    scan_ir(IrWidth, din, dout, sin);
    check_ir(dout[IrWidth-1:0], IrCapture, "Capture-IR pattern");
  endtask

  // Five TMS-high clocks, then settle in Run-Test-Idle
  task automatic tap_reset();
    repeat (5) step(1'b1, 1'b0);
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
  endtask

  task automatic randomize_chains();
    int c;
    for (c = 0; c < 3; c++)
    begin
      chain_ret[c] = {$urandom(), $urandom()};
    end
  endtask

  task automatic check_user_sels(input logic mem, input logic fifo, input logic conf);
    @(negedge tck);  // Decode settled after the latch edge
    check_bit(memory_sel_o, mem, "memory select");
    check_bit(fifo_sel_o, fifo, "fifo select");
    check_bit(confreg_sel_o, conf, "confreg select");
  endtask

  // BYPASS: captured 0 first, then TDI one bit late
  task automatic check_bypass(input int n, input logic [63:0] din, input logic [63:0] dout);
    int i;
    for (i = 0; i < n; i++)
    begin
      check_bit(dout[i], (i == 0) ? 1'b0 : din[i-1], $sformatf("bypass bit %0d", i));
    end
  endtask

  task automatic test_idcode();
    logic [63:0] din;
    logic [63:0] dout;
    logic [63:0] sin;
    din = {$urandom(), $urandom()};
    scan_dr(64, din, dout, sin);
    check_idcode(dout[31:0], DefaultIdcode, "IDCODE after reset");
    check_idcode(dout[63:32], din[31:0], "IDCODE shifted-through bits");
  endtask

  task automatic test_ir_bypass();
    logic [63:0] din;
    logic [63:0] dout;
    logic [63:0] sin;
    load_ir(InstrBypass);
    din = {$urandom(), $urandom()};
    scan_dr(16, din, dout, sin);
    check_bypass(16, din, dout);
  endtask

  task automatic test_user_chains();
    ir_t codes [3];
    logic [63:0] din;
    logic [63:0] dout;
    logic [63:0] sin;
    int j;
    int i;
    codes[0] = InstrMemory;
    codes[1] = InstrFifo;
    codes[2] = InstrConfreg;
    for (j = 0; j < 3; j++)
    begin
      load_ir(codes[j]);
      check_user_sels(j == 0, j == 1, j == 2);
      randomize_chains();
      din = {$urandom(), $urandom()};
      scan_dr(16, din, dout, sin);
      for (i = 0; i < 16; i++)
      begin
        check_bit(dout[i], chain_ret[j][i], $sformatf("chain %0d return bit %0d", j, i));
        check_bit(sin[i], din[i], $sformatf("scan_in bit %0d", i));
      end
    end
  endtask

  task automatic test_undefined_instr();
    logic [63:0] din;
    logic [63:0] dout;
    logic [63:0] sin;
    load_ir(5'b01010);
    check_user_sels(1'b0, 1'b0, 1'b0);
    din = {$urandom(), $urandom()};
    scan_dr(16, din, dout, sin);
    check_bypass(16, din, dout);
  endtask

  task automatic test_dr_strobes();
    logic [63:0] dout;
    logic [63:0] sin;
    cap_cnt   = 0;
    shift_cnt = 0;
    upd_cnt   = 0;
    count_en  = 1'b1;
    scan_dr(9, '0, dout, sin);
    count_en  = 1'b0;
    check_count(cap_cnt, 1, CaptureDr);
    check_count(shift_cnt, 9, ShiftDr);
    check_count(upd_cnt, 1, UpdateDr);
  endtask

  task automatic test_tms_reset();
    logic [63:0] dout;
    logic [63:0] sin;
    load_ir(InstrConfreg);
    check_user_sels(1'b0, 1'b0, 1'b1);
    tap_reset();
    check_user_sels(1'b0, 1'b0, 1'b0);  // IDCODE active again
    scan_dr(32, '0, dout, sin);
    check_idcode(dout[31:0], DefaultIdcode, "IDCODE after TMS reset");
  endtask

  task automatic print_counts();
    $display("errors: idcode %0d, ir %0d, bit %0d, count %0d",
             idcode_errs, ir_errs, bit_errs, count_errs);
  endtask

  // Watchdog
  initial
  begin
    #(WatchdogNs);
    $display("watchdog expired, tests did not finish in time");
    print_counts();
    $display("Result: FAILED");
    $finish;
  end

  initial
  begin
    tms_i         = 1'b1;
    td_i          = 1'b0;
    memory_out_i  = 1'b0;
    fifo_out_i    = 1'b0;
    confreg_out_i = 1'b0;
    count_en      = 1'b0;
    idcode_errs   = 0;
    ir_errs       = 0;
    bit_errs      = 0;
    count_errs    = 0;
    chain_ret[0]  = '0;
    chain_ret[1]  = '0;
    chain_ret[2]  = '0;
    void'($urandom(32'h701d1056));
    @(posedge rst_n);
    tap_reset();
    test_idcode();
    test_ir_bypass();
    test_user_chains();
    test_undefined_instr();
    test_dr_strobes();
    test_tms_reset();
    print_counts();
    if (idcode_errs + ir_errs + bit_errs + count_errs == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
